// File: hw/sata_cmd_pkg.sv
// ATA opcodes, status bit positions, FSM state enums and command layer structs
package sata_cmd_pkg;

  // Extended DMA opcodes issued for user read and write requests
  localparam logic [7:0] CMD_DMA_READ_EX  = 8'h25;
  localparam logic [7:0] CMD_DMA_WRITE_EX = 8'h35;

  // Bit positions inside the device status byte
  localparam int STATUS_BSY_BIT = 7;
  localparam int STATUS_DRQ_BIT = 3;
  localparam int STATUS_ERR_BIT = 0;

  // Features field restored after each D2H register FIS
  localparam logic [15:0] DEFAULT_FEATURES = 16'h0000;

  // User side command request, 88 bits
  typedef struct packed {
    logic [7:0]  command;
    logic [15:0] features;
    logic [15:0] sector_count;
    logic [47:0] lba;
  } user_cmd_t;

  // Host to device register FIS fields, 108 bits
  typedef struct packed {
    logic [7:0]  command;
    logic [15:0] features;
    logic [7:0]  control;
    logic [3:0]  port_mult;
    logic [7:0]  device;
    logic [47:0] lba;
    logic [15:0] sector_count;
  } h2d_reg_t;

  // Receive strobes from the transport layer
  typedef struct packed {
    logic dma_activate;
    logic d2h_reg;
    logic pio_setup;
    logic d2h_data;
    logic set_device_bits;
  } tl_event_t;

  // Device values, valid while the matching event strobe is high
  typedef struct packed {
    logic [7:0] d2h_status;
    logic [7:0] pio_e_status;
    logic       pio_direction;
  } dev_report_t;

  // Control machine: idle or inside a PIO transfer
  typedef enum logic [1:0] {
    CTRL_IDLE      = 2'd0,
    CTRL_PIO_READ  = 2'd1,
    CTRL_PIO_WRITE = 2'd2
  } ctrl_state_t;

  // Read machine: idle or waiting for the closing D2H register FIS
  typedef enum logic [1:0] {
    RD_IDLE      = 2'd0,
    RD_WAIT_DATA = 2'd1
  } read_state_t;

  // Write machine: one loop per DMA activate
  typedef enum logic [1:0] {
    WR_IDLE         = 2'd0,
    WR_WAIT_DMA_ACT = 2'd1,
    WR_WAIT_DATA    = 2'd2,
    WR_SEND_DATA    = 2'd3
  } write_state_t;

endpackage

// File: hw/sata_h2d_builder.sv
// H2D register builder: opcode select, held features, LBA and count, command strobe
module sata_h2d_builder #(
  parameter logic [3:0] PORT_MULT  = 4'h0,
  parameter logic [7:0] DEVICE_REG = 8'h40
) (
  input  logic                    clk,
  input  logic                    command_layer_reset,
  input  logic                    linkup,
  input  sata_cmd_pkg::user_cmd_t user_cmd,
  input  logic                    read_data_stb,
  input  logic                    write_data_stb,
  input  logic                    send_user_command_stb,
  input  logic                    d2h_reg_stb,
  input  logic                    srst,
  output sata_cmd_pkg::h2d_reg_t  h2d,
  output logic                    t_send_command_stb
);

  logic        layer_clear;
  logic [7:0]  command_sel;
  logic [7:0]  command_q;
  logic [15:0] features_q;
  logic [47:0] lba_q;
  logic [15:0] sector_count_q;

  // Link loss acts like a reset
  assign layer_clear = command_layer_reset || !linkup;

  // Any user request becomes a register FIS
  assign t_send_command_stb = read_data_stb || write_data_stb || send_user_command_stb;

  // Write wins over read, read over user opcode
  always_comb begin
    if (write_data_stb) begin
      command_sel = sata_cmd_pkg::CMD_DMA_WRITE_EX;
    end else if (read_data_stb) begin
      command_sel = sata_cmd_pkg::CMD_DMA_READ_EX;
    end else if (send_user_command_stb) begin
      command_sel = user_cmd.command;
    end else begin
      command_sel = command_q;
    end
  end

  always_ff @(posedge clk) begin
    if (layer_clear) begin
      command_q  <= '0;
      features_q <= sata_cmd_pkg::DEFAULT_FEATURES;
    end else begin
      if (t_send_command_stb) begin
        command_q <= command_sel;
      end
      // Device status closes the command, features go back to default
      if (d2h_reg_stb) begin
        features_q <= sata_cmd_pkg::DEFAULT_FEATURES;
      end
      // A new user command overrides the restore
      if (send_user_command_stb) begin
        features_q <= user_cmd.features;
      end
    end
  end

  // Address and count held between requests
  always_ff @(posedge clk) begin
    if (t_send_command_stb) begin
      lba_q          <= user_cmd.lba;
      sector_count_q <= user_cmd.sector_count;
    end
  end

  always_comb begin
    h2d.command      = command_sel;
    h2d.features     = features_q;
    // SRST sits in bit 2 of device control
    h2d.control      = {5'b00000, srst, 2'b00};
    h2d.port_mult    = PORT_MULT;
    h2d.device       = DEVICE_REG;
    // Bypass so the fields are valid with the strobe
    h2d.lba          = t_send_command_stb ? user_cmd.lba : lba_q;
    h2d.sector_count = t_send_command_stb ? user_cmd.sector_count : sector_count_q;
  end

  // User requests are mutually exclusive
  a_one_request: assert property (@(posedge clk) disable iff (layer_clear)
    $onehot0({read_data_stb, write_data_stb, send_user_command_stb}));

endmodule

// File: hw/sata_control_fsm.sv
// Control FSM: soft reset handshake, status byte, busy flag, PIO flow, layer ready
module sata_control_fsm (
  input  logic                      clk,
  input  logic                      command_layer_reset,
  input  logic                      linkup,
  input  sata_cmd_pkg::tl_event_t   tl_event,
  input  sata_cmd_pkg::dev_report_t dev_report,
  input  logic                      t_send_command_stb,
  input  logic                      soft_reset_request,
  input  logic                      send_sync_escape,
  input  logic                      t_if_activate,
  input  logic                      transport_layer_ready,
  input  logic                      read_active,
  input  logic                      write_active,
  output logic                      srst,
  output logic                      t_send_control_stb,
  output logic                      pio_data_ready,
  output logic                      sata_busy,
  output logic                      hard_drive_error,
  output logic                      command_layer_ready
);

  sata_cmd_pkg::ctrl_state_t state;
  logic                      layer_clear;
  logic [7:0]                status;

  assign layer_clear = command_layer_reset || !linkup;

  // Ready only when every machine rests and the transport can take a FIS
  assign command_layer_ready = (state == sata_cmd_pkg::CTRL_IDLE) &&
                               !read_active && !write_active &&
                               transport_layer_ready;

  assign hard_drive_error = status[sata_cmd_pkg::STATUS_ERR_BIT];

  always_ff @(posedge clk) begin
    if (layer_clear) begin
      state              <= sata_cmd_pkg::CTRL_IDLE;
      srst               <= 1'b0;
      t_send_control_stb <= 1'b0;
      pio_data_ready     <= 1'b0;
      status             <= 8'h00;
      // Device state unknown until the first register FIS
      sata_busy          <= 1'b1;
    end else begin
      // Strobes default low
      t_send_control_stb <= 1'b0;
      pio_data_ready     <= 1'b0;

      // Busy tracking
      if (tl_event.d2h_reg) begin
        sata_busy <= 1'b0;
      end
      if (t_send_command_stb || t_send_control_stb) begin
        sata_busy <= 1'b1;
      end

      case (state)
        sata_cmd_pkg::CTRL_IDLE: begin
          // First control FIS, SRST set
          if (soft_reset_request && !srst) begin
            srst               <= 1'b1;
            t_send_control_stb <= 1'b1;
          end
          // Second control FIS once the request drops
          // Spaced away from the first one
          if (command_layer_ready && !soft_reset_request && srst &&
              !t_send_control_stb) begin
            srst               <= 1'b0;
            t_send_control_stb <= 1'b1;
          end

          // Device starts a PIO transfer
          if (tl_event.pio_setup) begin
            if (dev_report.pio_direction) begin
              state <= sata_cmd_pkg::CTRL_PIO_READ;
            end else begin
              state <= sata_cmd_pkg::CTRL_PIO_WRITE;
            end
          end

          // Status capture
          if (tl_event.set_device_bits || tl_event.d2h_reg) begin
            status <= dev_report.d2h_status;
          end
        end

        sata_cmd_pkg::CTRL_PIO_READ: begin
          // Data FIS belongs to this PIO read
          if (tl_event.d2h_data) begin
            pio_data_ready <= 1'b1;
            status         <= dev_report.pio_e_status;
            state          <= sata_cmd_pkg::CTRL_IDLE;
          end
        end

        sata_cmd_pkg::CTRL_PIO_WRITE: begin
          // Transport took the outgoing buffer
          if (t_if_activate) begin
            status <= dev_report.pio_e_status;
            state  <= sata_cmd_pkg::CTRL_IDLE;
          end
        end

        default: begin
          state <= sata_cmd_pkg::CTRL_IDLE;
        end
      endcase

      // Sync escape aborts any flow
      if (send_sync_escape) begin
        state     <= sata_cmd_pkg::CTRL_IDLE;
        sata_busy <= 1'b0;
      end
    end
  end

  // Two control FISes never go out back to back
  a_ctrl_spacing: assert property (@(posedge clk) disable iff (layer_clear)
    t_send_control_stb |=> !t_send_control_stb);

endmodule

// File: hw/sata_read_fsm.sv
// Read FSM: outstanding DMA read tracking and sync escape generation
module sata_read_fsm (
  input  logic clk,
  input  logic command_layer_reset,
  input  logic linkup,
  input  logic read_data_stb,
  input  logic command_layer_ready,
  input  logic d2h_reg_stb,
  input  logic send_sync_escape,
  input  logic soft_reset_request,
  output logic read_active,
  output logic sync_escape
);

  sata_cmd_pkg::read_state_t state;
  logic                      layer_clear;

  assign layer_clear = command_layer_reset || !linkup;

  // Busy level back to the control FSM
  assign read_active = (state != sata_cmd_pkg::RD_IDLE);

  always_ff @(posedge clk) begin
    if (layer_clear) begin
      state       <= sata_cmd_pkg::RD_IDLE;
      sync_escape <= 1'b0;
    end else begin
      // User escape, or a soft reset cutting a read short
      sync_escape <= send_sync_escape || (soft_reset_request && read_active);

      case (state)
        sata_cmd_pkg::RD_IDLE: begin
          // New read only from a quiet layer
          if (command_layer_ready && read_data_stb) begin
            state <= sata_cmd_pkg::RD_WAIT_DATA;
          end
        end
        sata_cmd_pkg::RD_WAIT_DATA: begin
          // Data arrives on the transport, the state only marks busy
          if (d2h_reg_stb) begin
            state <= sata_cmd_pkg::RD_IDLE;
          end
        end
        default: begin
          state <= sata_cmd_pkg::RD_IDLE;
        end
      endcase

      // Abort paths
      if (send_sync_escape || soft_reset_request) begin
        state <= sata_cmd_pkg::RD_IDLE;
      end
    end
  end

endmodule

// File: hw/sata_write_fsm.sv
// Write FSM: DMA activate wait, buffer ready gating and data FIS strobe
module sata_write_fsm (
  input  logic clk,
  input  logic command_layer_reset,
  input  logic linkup,
  input  logic write_data_stb,
  input  logic command_layer_ready,
  input  logic dma_activate_stb,
  input  logic d2h_reg_stb,
  input  logic send_sync_escape,
  input  logic soft_reset_request,
  input  logic tx_buffer_ready,
  input  logic t_if_activate,
  input  logic transport_layer_ready,
  output logic write_active,
  output logic t_if_ready,
  output logic t_send_data_stb
);

  sata_cmd_pkg::write_state_t state;
  logic                       layer_clear;
  logic                       dma_act_seen;
  logic                       tl_ready_en;
  logic                       write_abort;

  assign layer_clear = command_layer_reset || !linkup;

  // Device status or any escape ends the burst sequence
  assign write_abort = d2h_reg_stb || send_sync_escape || soft_reset_request;

  assign write_active = (state != sata_cmd_pkg::WR_IDLE);

  // Buffer offered to the transport only while enabled
  assign t_if_ready = tx_buffer_ready && tl_ready_en;

  always_ff @(posedge clk) begin
    if (layer_clear) begin
      state           <= sata_cmd_pkg::WR_IDLE;
      dma_act_seen    <= 1'b0;
      tl_ready_en     <= 1'b0;
      t_send_data_stb <= 1'b0;
    end else begin
      t_send_data_stb <= 1'b0;

      // Latch activate so a strobe is never lost
      if (dma_activate_stb) begin
        dma_act_seen <= 1'b1;
      end
      // Transport took the buffer
      if (tl_ready_en && t_if_activate) begin
        tl_ready_en <= 1'b0;
      end

      case (state)
        sata_cmd_pkg::WR_IDLE: begin
          if (command_layer_ready && write_data_stb) begin
            state <= sata_cmd_pkg::WR_WAIT_DMA_ACT;
          end
        end
        sata_cmd_pkg::WR_WAIT_DMA_ACT: begin
          // Device can take the next data FIS
          if (dma_act_seen) begin
            dma_act_seen <= 1'b0;
            tl_ready_en  <= 1'b1;
            state        <= sata_cmd_pkg::WR_WAIT_DATA;
          end
        end
        sata_cmd_pkg::WR_WAIT_DATA: begin
          if (t_if_activate) begin
            state <= sata_cmd_pkg::WR_SEND_DATA;
          end
        end
        sata_cmd_pkg::WR_SEND_DATA: begin
          // Holds here for as long as the transport stalls
          if (transport_layer_ready) begin
            t_send_data_stb <= 1'b1;
            state           <= sata_cmd_pkg::WR_WAIT_DMA_ACT;
          end
        end
        default: begin
          state <= sata_cmd_pkg::WR_IDLE;
        end
      endcase

      // Back to idle, buffer withdrawn
      if (write_abort) begin
        state       <= sata_cmd_pkg::WR_IDLE;
        tl_ready_en <= 1'b0;
      end
    end
  end

  // Data FIS only follows a ready transport
  a_data_after_ready: assert property (@(posedge clk) disable iff (layer_clear)
    t_send_data_stb |-> $past(transport_layer_ready));

endmodule

// File: hw/sata_command_layer.sv
// SATA command layer top: builder, control, read and write FSM instances
module sata_command_layer #(
  parameter logic [3:0] PORT_MULT  = 4'h0,
  parameter logic [7:0] DEVICE_REG = 8'h40
) (
  input  logic                      clk,
  input  logic                      command_layer_reset,
  input  sata_cmd_pkg::user_cmd_t   user_cmd,
  input  logic                      read_data_stb,
  input  logic                      write_data_stb,
  input  logic                      send_user_command_stb,
  input  logic                      send_sync_escape,
  input  logic                      soft_reset_request,
  input  logic                      linkup,
  input  logic                      transport_layer_ready,
  input  logic                      tx_buffer_ready,
  input  sata_cmd_pkg::tl_event_t   tl_event,
  input  sata_cmd_pkg::dev_report_t dev_report,
  input  logic                      t_if_activate,
  output sata_cmd_pkg::h2d_reg_t    h2d,
  output logic                      t_send_command_stb,
  output logic                      t_send_control_stb,
  output logic                      t_send_data_stb,
  output logic                      sync_escape,
  output logic                      pio_data_ready,
  output logic                      command_layer_ready,
  output logic                      sata_busy,
  output logic                      hard_drive_error,
  output logic                      t_if_ready
);

  // Inter-machine wires
  logic srst;
  logic read_active;
  logic write_active;

  // Outgoing register FIS contents
  sata_h2d_builder #(
    .PORT_MULT  (PORT_MULT),
    .DEVICE_REG (DEVICE_REG)
  ) u_builder (
    .clk                   (clk),
    .command_layer_reset   (command_layer_reset),
    .linkup                (linkup),
    .user_cmd              (user_cmd),
    .read_data_stb         (read_data_stb),
    .write_data_stb        (write_data_stb),
    .send_user_command_stb (send_user_command_stb),
    .d2h_reg_stb           (tl_event.d2h_reg),
    .srst                  (srst),
    .h2d                   (h2d),
    .t_send_command_stb    (t_send_command_stb)
  );

  // Soft reset, status and PIO
  sata_control_fsm u_control (
    .clk                   (clk),
    .command_layer_reset   (command_layer_reset),
    .linkup                (linkup),
    .tl_event              (tl_event),
    .dev_report            (dev_report),
    .t_send_command_stb    (t_send_command_stb),
    .soft_reset_request    (soft_reset_request),
    .send_sync_escape      (send_sync_escape),
    .t_if_activate         (t_if_activate),
    .transport_layer_ready (transport_layer_ready),
    .read_active           (read_active),
    .write_active          (write_active),
    .srst                  (srst),
    .t_send_control_stb    (t_send_control_stb),
    .pio_data_ready        (pio_data_ready),
    .sata_busy             (sata_busy),
    .hard_drive_error      (hard_drive_error),
    .command_layer_ready   (command_layer_ready)
  );

  sata_read_fsm u_read (
    .clk                 (clk),
    .command_layer_reset (command_layer_reset),
    .linkup              (linkup),
    .read_data_stb       (read_data_stb),
    .command_layer_ready (command_layer_ready),
    .d2h_reg_stb         (tl_event.d2h_reg),
    .send_sync_escape    (send_sync_escape),
    .soft_reset_request  (soft_reset_request),
    .read_active         (read_active),
    .sync_escape         (sync_escape)
  );

  sata_write_fsm u_write (
    .clk                   (clk),
    .command_layer_reset   (command_layer_reset),
    .linkup                (linkup),
    .write_data_stb        (write_data_stb),
    .command_layer_ready   (command_layer_ready),
    .dma_activate_stb      (tl_event.dma_activate),
    .d2h_reg_stb           (tl_event.d2h_reg),
    .send_sync_escape      (send_sync_escape),
    .soft_reset_request    (soft_reset_request),
    .tx_buffer_ready       (tx_buffer_ready),
    .t_if_activate         (t_if_activate),
    .transport_layer_ready (transport_layer_ready),
    .write_active          (write_active),
    .t_if_ready            (t_if_ready),
    .t_send_data_stb       (t_send_data_stb)
  );

endmodule

// File: verif/tb_sata_command_layer.sv
// Testbench for the SATA command layer: clock, reset, check task, directed tests
module tb_sata_command_layer;

  // Signal selectors for the wait and pulse count helpers
  localparam int SEL_READY    = 0;
  localparam int SEL_CTRL     = 1;
  localparam int SEL_DATA     = 2;
  localparam int SEL_SYNC     = 3;
  localparam int SEL_PIO      = 4;
  localparam int SEL_IF_READY = 5;

  // Register values handed to the DUT, away from the defaults
  localparam logic [3:0] EXP_PORT_MULT = 4'h3;
  localparam logic [7:0] EXP_DEVICE    = 8'he0;

  logic                      clk;
  logic                      command_layer_reset;
  sata_cmd_pkg::user_cmd_t   user_cmd;
  logic                      read_data_stb;
  logic                      write_data_stb;
  logic                      send_user_command_stb;
  logic                      send_sync_escape;
  logic                      soft_reset_request;
  logic                      linkup;
  logic                      transport_layer_ready;
  logic                      tx_buffer_ready;
  sata_cmd_pkg::tl_event_t   tl_event;
  sata_cmd_pkg::dev_report_t dev_report;
  logic                      t_if_activate;
  sata_cmd_pkg::h2d_reg_t    h2d;
  logic                      t_send_command_stb;
  logic                      t_send_control_stb;
  logic                      t_send_data_stb;
  logic                      sync_escape;
  logic                      pio_data_ready;
  logic                      command_layer_ready;
  logic                      sata_busy;
  logic                      hard_drive_error;
  logic                      t_if_ready;
  string                     test_name;
  int                        n;
  logic [47:0]               lba;
  logic [15:0]               cnt;

  // Port names match one to one
  sata_command_layer #(.PORT_MULT(EXP_PORT_MULT), .DEVICE_REG(EXP_DEVICE)) DUT (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic check(input string what, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERR %s %s expected %0h actual %0h", test_name, what, expected, actual);
      $display("Errors found");
      $fatal(1, "Value mismatch");
    end
  endtask

  function automatic logic probe(input int sel);
    case (sel)
      SEL_READY:    probe = command_layer_ready;
      SEL_CTRL:     probe = t_send_control_stb;
      SEL_DATA:     probe = t_send_data_stb;
      SEL_SYNC:     probe = sync_escape;
      SEL_PIO:      probe = pio_data_ready;
      SEL_IF_READY: probe = t_if_ready;
      default:      probe = 1'b0;
    endcase
  endfunction

  // Polls on falling edges where outputs have settled
  task automatic wait_for(input string what, input int sel, input int limit);
    int polls;
    polls = 0;
    @(negedge clk);
    while (!probe(sel)) begin
      polls++;
      if (polls >= limit) begin
        $display("Errors found");
        $fatal(1, "Timeout in %s while waiting for %s", test_name, what);
      end
      @(negedge clk);
    end
  endtask

  task automatic count_pulses(input int sel, input int cycles, output int pulses);
    pulses = 0;
    repeat (cycles) begin
      @(negedge clk);
      if (probe(sel)) pulses++;
    end
  endtask

  task automatic pick_lba_count(output logic [47:0] lba_o, output logic [15:0] cnt_o);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $urandom();
    lo = $urandom();
    lba_o = {hi[15:0], lo};
    cnt_o = hi[31:16];
  endtask

  // One cycle D2H register FIS with its status byte
  task automatic send_d2h(input logic [7:0] status);
    @(posedge clk);
    tl_event.d2h_reg      <= 1'b1;
    dev_report.d2h_status <= status;
    @(posedge clk);
    tl_event.d2h_reg      <= 1'b0;
  endtask

  task automatic test_after_reset;
    test_name = "after_reset";
    @(negedge clk);
    check("ready", 64'h1, 64'(command_layer_ready));
    check("busy", 64'h1, 64'(sata_busy));
    check("strobes", 64'h0, 64'({t_send_command_stb, t_send_control_stb,
                                 t_send_data_stb, sync_escape, pio_data_ready}));
    check("t_if_ready", 64'h0, 64'(t_if_ready));
    check("port mult", 64'(EXP_PORT_MULT), 64'(h2d.port_mult));
    check("device", 64'(EXP_DEVICE), 64'(h2d.device));
  endtask

  task automatic test_dma_read;
    test_name = "dma_read";
    pick_lba_count(lba, cnt);
    @(posedge clk);
    user_cmd.lba          <= lba;
    user_cmd.sector_count <= cnt;
    read_data_stb         <= 1'b1;
    // Opcode and fields valid with the strobe
    @(negedge clk);
    check("command strobe", 64'h1, 64'(t_send_command_stb));
    check("command", 64'h25, 64'(h2d.command));
    check("lba", 64'(lba), 64'(h2d.lba));
    check("sector count", 64'(cnt), 64'(h2d.sector_count));
    @(posedge clk);
    read_data_stb <= 1'b0;
    count_pulses(SEL_READY, 4, n);
    check("ready while reading", 64'h0, 64'(n));
    check("held lba", 64'(lba), 64'(h2d.lba));
    // Status with the error bit set
    send_d2h(8'h51);
    @(negedge clk);
    check("error", 64'h1, 64'(hard_drive_error));
    check("busy", 64'h0, 64'(sata_busy));
    check("ready", 64'h1, 64'(command_layer_ready));
  endtask

  task automatic test_sync_escape;
    test_name = "sync_escape";
    @(posedge clk);
    read_data_stb <= 1'b1;
    @(posedge clk);
    read_data_stb <= 1'b0;
    @(negedge clk);
    check("ready while reading", 64'h0, 64'(command_layer_ready));
    @(posedge clk);
    send_sync_escape <= 1'b1;
    @(posedge clk);
    send_sync_escape <= 1'b0;
    wait_for("sync escape", SEL_SYNC, 5);
    check("busy", 64'h0, 64'(sata_busy));
    count_pulses(SEL_SYNC, 4, n);
    check("extra sync escape", 64'h0, 64'(n));
    check("ready", 64'h1, 64'(command_layer_ready));
  endtask

  task automatic test_dma_write;
    test_name = "dma_write";
    pick_lba_count(lba, cnt);
    @(posedge clk);
    user_cmd.lba          <= lba;
    user_cmd.sector_count <= cnt;
    write_data_stb        <= 1'b1;
    tx_buffer_ready       <= 1'b1;
    @(negedge clk);
    check("command strobe", 64'h1, 64'(t_send_command_stb));
    check("command", 64'h35, 64'(h2d.command));
    check("lba", 64'(lba), 64'(h2d.lba));
    @(posedge clk);
    write_data_stb <= 1'b0;
    // No buffer offer before DMA activate
    @(negedge clk);
    check("t_if_ready early", 64'h0, 64'(t_if_ready));
    @(posedge clk);
    tl_event.dma_activate <= 1'b1;
    @(posedge clk);
    tl_event.dma_activate <= 1'b0;
    wait_for("t_if_ready", SEL_IF_READY, 8);
    @(posedge clk);
    tx_buffer_ready <= 1'b0;
    @(negedge clk);
    check("t_if_ready follows buffer", 64'h0, 64'(t_if_ready));
    // Transport takes the buffer while stalling the data FIS
    @(posedge clk);
    tx_buffer_ready       <= 1'b1;
    t_if_activate         <= 1'b1;
    transport_layer_ready <= 1'b0;
    @(negedge clk);
    check("t_if_ready offered", 64'h1, 64'(t_if_ready));
    @(posedge clk);
    t_if_activate <= 1'b0;
    @(negedge clk);
    check("t_if_ready withdrawn", 64'h0, 64'(t_if_ready));
    count_pulses(SEL_DATA, 5, n);
    check("data strobe under back-pressure", 64'h0, 64'(n));
    @(posedge clk);
    transport_layer_ready <= 1'b1;
    wait_for("data strobe", SEL_DATA, 8);
    count_pulses(SEL_DATA, 4, n);
    check("extra data strobe", 64'h0, 64'(n));
    // Device status ends the write
    send_d2h(8'h50);
    @(negedge clk);
    check("error", 64'h0, 64'(hard_drive_error));
    check("ready", 64'h1, 64'(command_layer_ready));
  endtask

  task automatic test_soft_reset;
    test_name = "soft_reset";
    @(posedge clk);
    soft_reset_request <= 1'b1;
    wait_for("first control strobe", SEL_CTRL, 5);
    check("srst set", 64'h04, 64'(h2d.control));
    count_pulses(SEL_CTRL, 4, n);
    check("control strobe while held", 64'h0, 64'(n));
    @(posedge clk);
    soft_reset_request <= 1'b0;
    wait_for("second control strobe", SEL_CTRL, 5);
    check("srst clear", 64'h00, 64'(h2d.control));
    count_pulses(SEL_CTRL, 3, n);
    check("extra control strobe", 64'h0, 64'(n));
    check("busy", 64'h1, 64'(sata_busy));
  endtask

  task automatic test_pio_user_command;
    logic [15:0] features;
    test_name = "pio_user_command";
    features = 16'($urandom()) | 16'h0001;
    @(posedge clk);
    user_cmd.command      <= 8'hec;
    user_cmd.features     <= features;
    send_user_command_stb <= 1'b1;
    @(negedge clk);
    check("command strobe", 64'h1, 64'(t_send_command_stb));
    check("command", 64'hec, 64'(h2d.command));
    @(posedge clk);
    send_user_command_stb <= 1'b0;
    @(negedge clk);
    check("held command", 64'hec, 64'(h2d.command));
    check("features", 64'(features), 64'(h2d.features));
    send_d2h(8'h50);
    @(negedge clk);
    check("features restored", 64'h0, 64'(h2d.features));
    // PIO read from the device
    @(posedge clk);
    tl_event.pio_setup       <= 1'b1;
    dev_report.pio_direction <= 1'b1;
    @(posedge clk);
    tl_event.pio_setup <= 1'b0;
    @(negedge clk);
    check("ready during pio", 64'h0, 64'(command_layer_ready));
    @(posedge clk);
    tl_event.d2h_data       <= 1'b1;
    dev_report.pio_e_status <= 8'h41;
    @(posedge clk);
    tl_event.d2h_data <= 1'b0;
    wait_for("pio data ready", SEL_PIO, 5);
    check("error from e_status", 64'h1, 64'(hard_drive_error));
    count_pulses(SEL_PIO, 3, n);
    check("extra pio data ready", 64'h0, 64'(n));
    check("ready", 64'h1, 64'(command_layer_ready));
  endtask

  initial begin
    void'($urandom(32'h9571_0555));
    command_layer_reset   <= 1'b1;
    user_cmd              <= '0;
    read_data_stb         <= 1'b0;
    write_data_stb        <= 1'b0;
    send_user_command_stb <= 1'b0;
    send_sync_escape      <= 1'b0;
    soft_reset_request    <= 1'b0;
    linkup                <= 1'b1;
    transport_layer_ready <= 1'b1;
    tx_buffer_ready       <= 1'b0;
    tl_event              <= '0;
    dev_report            <= '0;
    t_if_activate         <= 1'b0;
    repeat (2) @(posedge clk);
    command_layer_reset <= 1'b0;
    test_after_reset();
    test_dma_read();
    test_sync_escape();
    test_dma_write();
    test_soft_reset();
    test_pio_user_command();
    $display("No errors");
    $finish;
  end

endmodule

// File: sim.f
hw/sata_cmd_pkg.sv
hw/sata_h2d_builder.sv
hw/sata_control_fsm.sv
hw/sata_read_fsm.sv
hw/sata_write_fsm.sv
hw/sata_command_layer.sv
verif/tb_sata_command_layer.sv

// File: Makefile
# Verilator build and run for the SATA command layer testbench

VERILATOR ?= verilator
TOP       ?= tb_sata_command_layer
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

# Sources come from the file list, so a change to any of them rebuilds
SRCS := $(shell grep -v '^+' sim.f)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) sim.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f sim.f

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
